/* filelist.f */
hdl/ntt_pkg.sv
hdl/coef_regfile.sv
hdl/addr_gen.sv
hdl/operand_fetch.sv
hdl/butterfly_unit.sv
hdl/writeback.sv
hdl/ntt_top.sv
bench/ntt_checker.sv
bench/tb_ntt.sv

/* Makefile */
# Verilator simulation of the NTT core testbench

SIM := obj_dir/Vtb_ntt

.PHONY: run clean

run: $(SIM)
	./$(SIM) | awk '{ print } /^TEST RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

# Rebuilt only when a source or the file list changes
$(SIM): filelist.f $(wildcard hdl/*.sv bench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tb_ntt -f filelist.f -o Vtb_ntt

clean:
	rm -rf obj_dir

/* bench/tb_ntt.sv */
// Testbench top for the NTT core
// Clock, reset, BRAM model, xorshift stimulus, run sequence and watchdog
`timescale 1ns/1ps

module tb_ntt;

    import ntt_pkg::*;

    localparam int CLK_NS      = 4;
    // Copy, seven layers with drain, and some slack
    localparam int RUN_CYCLES  = NTT_N + NTT_LAYERS * (NTT_N / 2 + PIPE_DRAIN) + 64;
    localparam int N_RUNS      = 8;
    localparam int N_TESTS     = N_RUNS + 1;
    localparam int WATCHDOG_NS = (N_RUNS + 2) * RUN_CYCLES * CLK_NS;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  start;
    logic                  mode;
    logic                  done;
    bram_req_t             bram_a;
    bram_req_t             bram_b;
    bram_word_t            dout_a = '0;
    bram_word_t            dout_b = '0;

    // BRAM model and preload staging
    bram_word_t            bram [NTT_N];
    coef_t [NTT_N-1:0]     stage_vec;
    logic                  bram_load;

    logic                  run_begin;
    logic [1:0]            run_kind;
    logic [31:0]           rng_state;
    int                    timeouts;
    int                    err_count;
    int                    test_count;
    int                    fail_count;

    always #(CLK_NS / 2) clk = ~clk;

    // Registered read returns data one cycle after the address
    always @(posedge clk) begin
        if (bram_load) begin
            for (int i = 0; i < NTT_N; i++) begin
                bram[i] <= bram_word_t'(stage_vec[i]);
            end
        end else begin
            if (bram_a.we) begin
                bram[bram_a.addr] <= bram_a.wdata;
            end
            if (bram_b.we) begin
                bram[bram_b.addr] <= bram_b.wdata;
            end
        end
        dout_a <= bram[bram_a.addr];
        dout_b <= bram[bram_b.addr];
    end

    ntt_top uut (
        .clk           (clk),
        .rst           (rst),
        .i_start       (start),
        .i_mode        (mode),
        .o_done        (done),
        .o_bram_a      (bram_a),
        .o_bram_b      (bram_b),
        .i_bram_dout_a (dout_a),
        .i_bram_dout_b (dout_b)
    );

    ntt_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .i_run_begin (run_begin),
        .i_kind      (run_kind),
        .i_vec       (stage_vec),
        .i_done      (done),
        .i_bram_a    (bram_a),
        .i_bram_b    (bram_b),
        .o_errors    (err_count),
        .o_tests     (test_count),
        .o_failed    (fail_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < NTT_N; i++) begin
            rng_state    = xorshift32(rng_state);
            stage_vec[i] = coef_t'(rng_state % NTT_Q);
        end
    endtask

    task automatic fill_const(input coef_t val);
        for (int i = 0; i < NTT_N; i++) begin
            stage_vec[i] = val;
        end
    endtask

    task automatic fill_single(input int idx, input coef_t val);
        stage_vec      = '0;
        stage_vec[idx] = val;
    endtask

    // Next run starts from what the last one left in BRAM
    task automatic take_bram();
        for (int i = 0; i < NTT_N; i++) begin
            stage_vec[i] = bram[i][11:0];
        end
    endtask

    // Entered and left 1 ns after a rising edge
    // Poke adds extra starts in the copy phase and in the layers
    task automatic run_transform(input logic run_mode, input logic [1:0] kind, input bit poke);
        int n;
        bit seen;
        bram_load = 1'b1;
        @(posedge clk);
        #1;
        bram_load = 1'b0;
        run_begin = 1'b1;
        run_kind  = kind;
        start     = 1'b1;
        mode      = run_mode;
        @(posedge clk);
        #1;
        run_begin = 1'b0;
        start     = 1'b0;
        // Mode is latched at start so flipping it now must not matter
        mode      = poke ? !run_mode : run_mode;
        n         = 0;
        seen      = 1'b0;
        while (!seen && n < RUN_CYCLES) begin
            if (poke) begin
                start = (n == 100) || (n == 700);
            end
            @(posedge clk);
            #1;
            seen = done;
            n++;
        end
        start = 1'b0;
        if (!seen) begin
            $display("no o_done within %0d cycles of start at %0t", RUN_CYCLES, $time);
            timeouts++;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        mode      = 1'b0;
        bram_load = 1'b0;
        run_begin = 1'b0;
        run_kind  = 2'd0;
        stage_vec = '0;
        rng_state = 32'h1064d7cf;
        timeouts  = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle window watched by the checker
        repeat (8) @(posedge clk);
        #1;
        fill_random();
        run_transform(1'b0, 2'd0, 1'b0);
        fill_random();
        run_transform(1'b1, 2'd1, 1'b0);
        // Round trip
        fill_random();
        run_transform(1'b0, 2'd0, 1'b0);
        take_bram();
        run_transform(1'b1, 2'd2, 1'b0);
        // Edge vectors
        fill_const('0);
        run_transform(1'b0, 2'd0, 1'b0);
        fill_const(coef_t'(NTT_Q - 1));
        run_transform(1'b1, 2'd1, 1'b0);
        fill_single(37, coef_t'(1234));
        run_transform(1'b0, 2'd0, 1'b0);
        // Starts during copy and run are ignored
        fill_random();
        run_transform(1'b0, 2'd0, 1'b1);
        // Quiet period where a late done or write would show
        repeat (RUN_CYCLES) @(posedge clk);
        #1;
        $display("tests %0d of %0d, failed %0d, errors %0d, timeouts %0d",
                 test_count, N_TESTS, fail_count, err_count, timeouts);
        if (err_count == 0 && fail_count == 0 && timeouts == 0 && test_count == N_TESTS) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (test_count != N_TESTS) begin
                $display("only %0d of %0d tests were reported", test_count, N_TESTS);
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Hang guard sized from the run length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, simulation did not finish", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* bench/ntt_checker.sv */
// Scoreboard for the NTT core
// Reference NTT and INTT, BRAM write monitor, per-run comparison and test lines
`timescale 1ns/1ps

module ntt_checker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_run_begin,
    input  logic [1:0]                          i_kind,
    input  ntt_pkg::coef_t [ntt_pkg::NTT_N-1:0] i_vec,
    input  logic                                i_done,
    input  ntt_pkg::bram_req_t                  i_bram_a,
    input  ntt_pkg::bram_req_t                  i_bram_b,
    output int                                  o_errors,
    output int                                  o_tests,
    output int                                  o_failed
);

    import ntt_pkg::*;

    typedef coef_t [NTT_N-1:0] vec_t;

    // Expected contents, plus 128 x input of the previous run for round trips
    vec_t       exp_vec;
    vec_t       scaled_vec;
    vec_t       prev_vec = '0;
    bram_word_t got [NTT_N];
    int         wr_cnt [NTT_N];
    logic [1:0] kind = 2'd0;
    logic       active = 1'b0;
    logic       reset_reported = 1'b0;
    int         cyc = 0;
    int         errors = 0;
    int         run_errs = 0;
    int         tests = 0;
    int         failed = 0;

    assign o_errors = errors;
    assign o_tests  = tests;
    assign o_failed = failed;

    // Twiddle k is 17^bitrev7(k) mod q
    function automatic int zeta_of(int k);
        int rev;
        int z;
        rev = 0;
        for (int b = 0; b < NTT_LAYERS; b++) begin
            rev = (rev << 1) | ((k >> b) & 1);
        end
        z = 1;
        for (int e = 0; e < rev; e++) begin
            z = (z * ZETA_ROOT) % NTT_Q;
        end
        return z;
    endfunction

    // CT layers, len 128 down to 2, zeta index counting up from 1
    function automatic vec_t ref_ntt(vec_t a_in);
        int   a [NTT_N];
        vec_t r;
        int   k;
        int   t;
        int   z;
        for (int i = 0; i < NTT_N; i++) begin
            a[i] = int'(a_in[i]);
        end
        k = 1;
        for (int len = NTT_N / 2; len >= 2; len = len / 2) begin
            for (int st = 0; st < NTT_N; st += 2 * len) begin
                z = zeta_of(k);
                k++;
                for (int j = st; j < st + len; j++) begin
                    t          = (z * a[j + len]) % NTT_Q;
                    a[j + len] = (a[j] - t + NTT_Q) % NTT_Q;
                    a[j]       = (a[j] + t) % NTT_Q;
                end
            end
        end
        for (int i = 0; i < NTT_N; i++) begin
            r[i] = coef_t'(a[i]);
        end
        return r;
    endfunction

    // GS layers, len 2 up to 128, zeta index counting down from 127, no final scaling
    function automatic vec_t ref_intt(vec_t a_in);
        int   a [NTT_N];
        vec_t r;
        int   k;
        int   t;
        int   z;
        for (int i = 0; i < NTT_N; i++) begin
            a[i] = int'(a_in[i]);
        end
        k = NTT_N / 2 - 1;
        for (int len = 2; len <= NTT_N / 2; len = len * 2) begin
            for (int st = 0; st < NTT_N; st += 2 * len) begin
                z = zeta_of(k);
                k--;
                for (int j = st; j < st + len; j++) begin
                    t          = a[j];
                    a[j]       = (t + a[j + len]) % NTT_Q;
                    a[j + len] = (z * ((a[j + len] - t + NTT_Q) % NTT_Q)) % NTT_Q;
                end
            end
        end
        for (int i = 0; i < NTT_N; i++) begin
            r[i] = coef_t'(a[i]);
        end
        return r;
    endfunction

    // Forward then inverse leaves 128 x input
    function automatic vec_t scale128(vec_t v);
        vec_t r;
        for (int i = 0; i < NTT_N; i++) begin
            r[i] = coef_t'((128 * int'(v[i])) % NTT_Q);
        end
        return r;
    endfunction

    function automatic string kind_name(logic [1:0] k);
        if (k == 2'd0) begin
            return "forward NTT";
        end else if (k == 2'd1) begin
            return "inverse INTT";
        end
        return "round-trip INTT";
    endfunction

    task automatic flag_error(input string msg);
        $display("%s", msg);
        errors++;
        run_errs++;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (run_errs == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, run_errs);
        end
        run_errs = 0;
    endtask

    // Copy takes 256 cycles after the start, no write may land in it
    task automatic record_write(input bram_req_t req, input string port);
        if (req.we) begin
            if (cyc <= NTT_N + 1) begin
                flag_error($sformatf("BRAM write on port %s during the copy phase at %0t",
                                     port, $time));
            end
            got[req.addr] = req.wdata;
            wr_cnt[req.addr]++;
        end
    endtask

    task automatic finish_run();
        for (int i = 0; i < NTT_N; i++) begin
            if (wr_cnt[i] != 1) begin
                flag_error($sformatf("BRAM address %0d written %0d times", i, wr_cnt[i]));
            end else begin
                if (got[i] != bram_word_t'(exp_vec[i])) begin
                    flag_error($sformatf("mismatch at %0t: bram[%0d] = %0d, expected %0d",
                                         $time, i, got[i], exp_vec[i]));
                end
                if (kind == 2'd2 && got[i] != bram_word_t'(scaled_vec[i])) begin
                    flag_error($sformatf("mismatch at %0t: bram[%0d] = %0d, expected 128 x input %0d",
                                         $time, i, got[i], scaled_vec[i]));
                end
            end
        end
        report_test(kind_name(kind));
        active = 1'b0;
    endtask

    // Sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        if (i_run_begin && !rst) begin
            // Idle checks since reset make up the first test
            if (!reset_reported) begin
                report_test("reset and idle outputs");
                reset_reported = 1'b1;
            end
            kind       = i_kind;
            exp_vec    = (i_kind == 2'd0) ? ref_ntt(i_vec) : ref_intt(i_vec);
            scaled_vec = scale128(prev_vec);
            prev_vec   = i_vec;
            for (int i = 0; i < NTT_N; i++) begin
                got[i]    = '0;
                wr_cnt[i] = 0;
            end
            cyc    = 0;
            active = 1'b1;
        end else if (active && !rst) begin
            cyc++;
            record_write(i_bram_a, "A");
            record_write(i_bram_b, "B");
            if (i_done) begin
                finish_run();
            end
        end else begin
            // A second done or a stray write shows up here
            if (i_done) begin
                flag_error($sformatf("o_done pulsed with no run in progress at %0t", $time));
            end
            if (i_bram_a.we || i_bram_b.we) begin
                flag_error($sformatf("BRAM write with no run in progress at %0t", $time));
            end
        end
    end

endmodule

/* hdl/ntt_top.sv */
// NTT/INTT core top level
// BRAM to register file copy controller, write and BRAM port muxing
// Pipeline: addr_gen, operand_fetch, butterfly_unit, writeback
`timescale 1ns/1ps

module ntt_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_start,
    input  logic                i_mode,
    output logic                o_done,
    output ntt_pkg::bram_req_t  o_bram_a,
    output ntt_pkg::bram_req_t  o_bram_b,
    input  ntt_pkg::bram_word_t i_bram_dout_a,
    input  ntt_pkg::bram_word_t i_bram_dout_b
);

    import ntt_pkg::*;

    ctrl_state_t state;
    // Even base index of the pair being copied
    addr_t       copy_addr;
    logic        mode_q;
    logic        ag_start;
    logic        done_q;
    logic        copy_phase;

    bf_op_t      ag_op;
    bf_data_t    of_data;
    bf_res_t     bf_res;
    coef_t       rd_up;
    coef_t       rd_dn;

    rf_wr_t      copy_wr;
    rf_wr_t      wb_rf_wr;
    rf_wr_t      rf_wr;
    bram_req_t   wb_bram_a;
    bram_req_t   wb_bram_b;
    logic        wb_final;

    // Copy FSM
    // ISSUE drives the pair address, CAPTURE writes the returned words
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            copy_addr <= '0;
            mode_q    <= 1'b0;
            ag_start  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            ag_start <= 1'b0;
            done_q   <= 1'b0;
            case (state)
                IDLE: begin
                    // mode sampled with the start pulse
                    if (i_start) begin
                        state     <= COPY_ISSUE;
                        copy_addr <= '0;
                        mode_q    <= i_mode;
                    end
                end
                COPY_ISSUE: begin
                    state <= COPY_CAPTURE;
                end
                COPY_CAPTURE: begin
                    if (copy_addr == addr_t'(NTT_N - 2)) begin
                        // Last pair captured, kick the sequencer
                        state    <= RUN;
                        ag_start <= 1'b1;
                    end else begin
                        copy_addr <= copy_addr + addr_t'(2);
                        state     <= COPY_ISSUE;
                    end
                end
                RUN: begin
                    // Final butterfly written this cycle, done follows
                    if (wb_final) begin
                        done_q <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign o_done     = done_q;
    assign copy_phase = (state == COPY_ISSUE) || (state == COPY_CAPTURE);

    // BRAM read data is valid in CAPTURE, low 12 bits only
    assign copy_wr.en     = (state == COPY_CAPTURE);
    assign copy_wr.addr_a = copy_addr;
    assign copy_wr.addr_b = copy_addr + addr_t'(1);
    assign copy_wr.data_a = i_bram_dout_a[11:0];
    assign copy_wr.data_b = i_bram_dout_b[11:0];

    // Copy has priority; pipeline is idle during copy anyway
    assign rf_wr = copy_wr.en ? copy_wr : wb_rf_wr;

    // Reads only while copying, writeback requests otherwise
    always_comb begin
        if (copy_phase) begin
            o_bram_a = '{we: 1'b0, addr: copy_addr, wdata: '0};
            o_bram_b = '{we: 1'b0, addr: copy_addr + addr_t'(1), wdata: '0};
        end else begin
            o_bram_a = wb_bram_a;
            o_bram_b = wb_bram_b;
        end
    end

    coef_regfile u_regfile (
        .clk        (clk),
        .i_wr       (rf_wr),
        .i_raddr_up (ag_op.up_addr),
        .i_raddr_dn (ag_op.dn_addr),
        .o_rdata_up (rd_up),
        .o_rdata_dn (rd_dn)
    );

    addr_gen u_addr_gen (
        .clk     (clk),
        .rst     (rst),
        .i_start (ag_start),
        .i_mode  (mode_q),
        .o_op    (ag_op)
    );

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .rst        (rst),
        .i_op       (ag_op),
        .i_rdata_up (rd_up),
        .i_rdata_dn (rd_dn),
        .o_data     (of_data)
    );

    butterfly_unit u_butterfly (
        .clk    (clk),
        .rst    (rst),
        .i_data (of_data),
        .o_res  (bf_res)
    );

    writeback u_writeback (
        .clk      (clk),
        .rst      (rst),
        .i_res    (bf_res),
        .o_rf_wr  (wb_rf_wr),
        .o_bram_a (wb_bram_a),
        .o_bram_b (wb_bram_b),
        .o_final  (wb_final)
    );

endmodule

/* hdl/writeback.sv */
// Writeback stage: register file write and last-layer BRAM writes
`timescale 1ns/1ps

module writeback (
    input  logic               clk,
    input  logic               rst,
    input  ntt_pkg::bf_res_t   i_res,
    output ntt_pkg::rf_wr_t    o_rf_wr,
    output ntt_pkg::bram_req_t o_bram_a,
    output ntt_pkg::bram_req_t o_bram_b,
    output logic               o_final
);

    import ntt_pkg::*;

    logic bram_we;

    // Results leave the core only from the last layer
    assign bram_we = i_res.valid && i_res.last_layer;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_rf_wr  <= '0;
            o_bram_a <= '0;
            o_bram_b <= '0;
            o_final  <= 1'b0;
        end else begin
            o_rf_wr.en     <= i_res.valid;
            o_rf_wr.addr_a <= i_res.up_addr;
            o_rf_wr.addr_b <= i_res.dn_addr;
            o_rf_wr.data_a <= i_res.up_val;
            o_rf_wr.data_b <= i_res.dn_val;
            // Both BRAM ports written together, data zero-extended
            o_bram_a.we    <= bram_we;
            o_bram_a.addr  <= i_res.up_addr;
            o_bram_a.wdata <= bram_word_t'(i_res.up_val);
            o_bram_b.we    <= bram_we;
            o_bram_b.addr  <= i_res.dn_addr;
            o_bram_b.wdata <= bram_word_t'(i_res.dn_val);
            o_final        <= i_res.valid && i_res.final_op;
        end
    end

endmodule

/* hdl/butterfly_unit.sv */
// Two-stage modular butterfly
// CT in forward mode, GS in inverse mode, Barrett reduction
`timescale 1ns/1ps

module butterfly_unit (
    input  logic              clk,
    input  logic              rst,
    input  ntt_pkg::bf_data_t i_data,
    output ntt_pkg::bf_res_t  o_res
);

    import ntt_pkg::*;

    // Canonical (a + b) mod q
    function automatic coef_t add_mod(coef_t a, coef_t b);
        logic [12:0] s;
        s = {1'b0, a} + {1'b0, b};
        return (s >= 13'(NTT_Q)) ? coef_t'(s - 13'(NTT_Q)) : coef_t'(s);
    endfunction

    // Canonical (a - b) mod q
    function automatic coef_t sub_mod(coef_t a, coef_t b);
        return (a >= b) ? coef_t'(a - b) : coef_t'(a + coef_t'(NTT_Q) - b);
    endfunction

    // Stage 1 registers
    logic  s1_valid;
    logic  s1_last;
    logic  s1_final;
    logic  s1_inverse;
    addr_t s1_up_addr;
    addr_t s1_dn_addr;
    coef_t s1_up;
    coef_t s1_dn;
    prod_t s1_prod;

    // Multiplier operand, GS multiplies the difference
    coef_t mul_b;

    // Stage 2 reduction and outputs
    logic [PROD_W+12:0] q_full;
    logic [12:0]        q_est;
    logic [PROD_W:0]    r_wide;
    coef_t              t_red;
    coef_t              res_up;
    coef_t              res_dn;

    assign mul_b = i_data.inverse ? sub_mod(i_data.dn_val, i_data.up_val) : i_data.dn_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            s1_final   <= 1'b0;
            s1_inverse <= 1'b0;
        end else begin
            s1_valid   <= i_data.valid;
            s1_last    <= i_data.last_layer;
            s1_final   <= i_data.final_op;
            s1_inverse <= i_data.inverse;
        end
    end

    always_ff @(posedge clk) begin
        s1_up_addr <= i_data.up_addr;
        s1_dn_addr <= i_data.dn_addr;
        s1_up      <= i_data.up_val;
        s1_dn      <= i_data.dn_val;
        s1_prod    <= prod_t'(i_data.zeta) * prod_t'(mul_b);
    end

    // Quotient estimate is short by at most one, so one correction suffices
    assign q_full = (PROD_W+13)'(s1_prod) * (PROD_W+13)'(BARRETT_M);
    assign q_est  = q_full[PROD_W+12:BARRETT_K];
    assign r_wide = (PROD_W+1)'(s1_prod) - (PROD_W+1)'(q_est) * (PROD_W+1)'(NTT_Q);
    assign t_red  = (r_wide >= (PROD_W+1)'(NTT_Q)) ?
                    coef_t'(r_wide - (PROD_W+1)'(NTT_Q)) : coef_t'(r_wide);

    // forward: u + t, u - t; inverse: u + v, zeta * (v - u)
    assign res_up = s1_inverse ? add_mod(s1_up, s1_dn) : add_mod(s1_up, t_red);
    assign res_dn = s1_inverse ? t_red : sub_mod(s1_up, t_red);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_res <= '0;
        end else begin
            o_res.valid      <= s1_valid;
            o_res.last_layer <= s1_last;
            o_res.final_op   <= s1_final;
            o_res.up_addr    <= s1_up_addr;
            o_res.dn_addr    <= s1_dn_addr;
            o_res.up_val     <= res_up;
            o_res.dn_val     <= res_dn;
        end
    end

endmodule

/* hdl/operand_fetch.sv */
// Operand fetch stage with twiddle ROM
// ROM entry k holds 17^bitrev7(k) mod q, built at elaboration
`timescale 1ns/1ps

module operand_fetch (
    input  logic              clk,
    input  logic              rst,
    input  ntt_pkg::bf_op_t   i_op,
    input  ntt_pkg::coef_t    i_rdata_up,
    input  ntt_pkg::coef_t    i_rdata_dn,
    output ntt_pkg::bf_data_t o_data
);

    import ntt_pkg::*;

    typedef coef_t [NTT_N/2-1:0] zeta_tab_t;

    // Powers of the root first, then bit-reversed pick
    function automatic zeta_tab_t gen_zetas();
        zeta_tab_t   pw;
        zeta_tab_t   tab;
        int unsigned acc;
        int unsigned rev;
        acc = 1;
        for (int e = 0; e < NTT_N / 2; e++) begin
            pw[e] = coef_t'(acc);
            acc   = (acc * ZETA_ROOT) % NTT_Q;
        end
        for (int k = 0; k < NTT_N / 2; k++) begin
            rev = 0;
            for (int b = 0; b < NTT_LAYERS; b++) begin
                rev = rev | (((k >> b) & 1) << (NTT_LAYERS - 1 - b));
            end
            tab[k] = pw[rev];
        end
        return tab;
    endfunction

    localparam zeta_tab_t ZETAS = gen_zetas();

    // Register file data arrives combinationally for the current op
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_data <= '0;
        end else begin
            o_data.valid      <= i_op.valid;
            o_data.last_layer <= i_op.last_layer;
            o_data.final_op   <= i_op.final_op;
            o_data.inverse    <= i_op.inverse;
            o_data.up_addr    <= i_op.up_addr;
            o_data.dn_addr    <= i_op.dn_addr;
            o_data.up_val     <= i_rdata_up;
            o_data.dn_val     <= i_rdata_dn;
            // twiddle lookup by zeta index
            o_data.zeta       <= ZETAS[i_op.zidx];
        end
    end

endmodule

/* hdl/addr_gen.sv */
// Butterfly sequencer for forward and inverse transforms
// One operation per cycle, drain gap between layers
`timescale 1ns/1ps

module addr_gen (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_start,
    input  logic            i_mode,
    output ntt_pkg::bf_op_t o_op
);

    import ntt_pkg::*;

    logic       active;
    logic       mode_q;
    logic [2:0] gap_cnt;
    logic [2:0] layer;
    // Butterfly span, power of two
    addr_t      len;
    addr_t      grp_base;
    addr_t      offset;
    zidx_t      zidx;

    logic       issue;
    logic       grp_end;
    logic       last_layer;
    logic [8:0] next_base;

    // Issue only while running and outside the drain gap
    assign issue      = active && (gap_cnt == '0);
    assign grp_end    = (offset == len - addr_t'(1));
    assign next_base  = {1'b0, grp_base} + {len, 1'b0};
    assign last_layer = (layer == 3'(NTT_LAYERS - 1));

    // Operation is a function of the counter registers
    assign o_op.valid      = issue;
    assign o_op.last_layer = last_layer;
    assign o_op.final_op   = issue && last_layer && grp_end && next_base[8];
    assign o_op.inverse    = mode_q;
    assign o_op.up_addr    = grp_base + offset;
    assign o_op.dn_addr    = grp_base + offset + len;
    assign o_op.zidx       = zidx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            mode_q   <= 1'b0;
            gap_cnt  <= '0;
            layer    <= '0;
            len      <= '0;
            grp_base <= '0;
            offset   <= '0;
            zidx     <= '0;
        end else if (i_start && !active) begin
            active   <= 1'b1;
            mode_q   <= i_mode;
            gap_cnt  <= '0;
            layer    <= '0;
            grp_base <= '0;
            offset   <= '0;
            // Forward: CT from len 128, zeta 1 upward
            // Inverse: GS from len 2, zeta 127 downward
            len      <= i_mode ? addr_t'(2) : addr_t'(NTT_N / 2);
            zidx     <= i_mode ? zidx_t'(NTT_N / 2 - 1) : zidx_t'(1);
        end else if (gap_cnt != '0) begin
            gap_cnt <= gap_cnt - 1'b1;
        end else if (active) begin
            if (!grp_end) begin
                offset <= offset + 1'b1;
            end else begin
                offset <= '0;
                // One twiddle per group
                zidx   <= mode_q ? zidx - 1'b1 : zidx + 1'b1;
                if (!next_base[8]) begin
                    grp_base <= next_base[7:0];
                end else begin
                    // Layer done
                    grp_base <= '0;
                    layer    <= layer + 1'b1;
                    len      <= mode_q ? len << 1 : len >> 1;
                    if (last_layer) begin
                        active <= 1'b0;
                    end else begin
                        gap_cnt <= 3'(PIPE_DRAIN);
                    end
                end
            end
        end
    end

endmodule

/* hdl/coef_regfile.sv */
// Coefficient store, 256 x 12
// Two write ports on a common enable, two asynchronous read ports
`timescale 1ns/1ps

module coef_regfile (
    input  logic           clk,
    input  ntt_pkg::rf_wr_t i_wr,
    input  ntt_pkg::addr_t  i_raddr_up,
    input  ntt_pkg::addr_t  i_raddr_dn,
    output ntt_pkg::coef_t  o_rdata_up,
    output ntt_pkg::coef_t  o_rdata_dn
);

    import ntt_pkg::*;

    // Distributed RAM style array
    coef_t mem [NTT_N];

    // Both ports write on the same edge
    // Addresses never collide: copy writes a pair, butterflies write distinct indices
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr_a] <= i_wr.data_a;
            mem[i_wr.addr_b] <= i_wr.data_b;
        end
    end

    // Combinational reads feed operand fetch in the same cycle
    assign o_rdata_up = mem[i_raddr_up];
    assign o_rdata_dn = mem[i_raddr_dn];

endmodule

/* hdl/ntt_pkg.sv */
// Shared constants, data types and pipeline structs for the NTT core
package ntt_pkg;

    // Ring parameters
    localparam int NTT_Q      = 3329;
    localparam int NTT_N      = 256;
    localparam int NTT_LAYERS = 7;
    // Primitive 256th root of unity mod q
    localparam int ZETA_ROOT  = 17;
    // Idle cycles between layers, equal to op-to-write latency
    localparam int PIPE_DRAIN = 4;

    // Barrett constants, m = floor(2^24 / q)
    localparam int PROD_W     = 24;
    localparam int BARRETT_K  = PROD_W;
    localparam int BARRETT_M  = 5039;

    typedef logic [11:0]       coef_t;
    typedef logic [7:0]        addr_t;
    typedef logic [6:0]        zidx_t;
    typedef logic [15:0]       bram_word_t;
    typedef logic [PROD_W-1:0] prod_t;

    // Address generator output
    typedef struct packed {
        logic  valid;
        logic  last_layer;
        logic  final_op;
        logic  inverse;
        addr_t up_addr;
        addr_t dn_addr;
        zidx_t zidx;
    } bf_op_t;

    // Operand fetch output
    typedef struct packed {
        logic  valid;
        logic  last_layer;
        logic  final_op;
        logic  inverse;
        addr_t up_addr;
        addr_t dn_addr;
        coef_t up_val;
        coef_t dn_val;
        coef_t zeta;
    } bf_data_t;

    // Butterfly result
    typedef struct packed {
        logic  valid;
        logic  last_layer;
        logic  final_op;
        addr_t up_addr;
        addr_t dn_addr;
        coef_t up_val;
        coef_t dn_val;
    } bf_res_t;

    // Dual-port register file write, one shared enable
    typedef struct packed {
        logic  en;
        addr_t addr_a;
        addr_t addr_b;
        coef_t data_a;
        coef_t data_b;
    } rf_wr_t;

    typedef struct packed {
        logic       we;
        addr_t      addr;
        bram_word_t wdata;
    } bram_req_t;

    typedef enum logic [1:0] {
        IDLE,
        COPY_ISSUE,
        COPY_CAPTURE,
        RUN
    } ctrl_state_t;

endpackage
